// ==== design/ctrl_pkg.sv ====
// controller package: states, redirect sources, forwarding selects and bundled status types
package ctrl_pkg;

  //////////////////////////////
  // encodings
  //////////////////////////////

  // sequencer states, debug states removed
  typedef enum logic [2:0] {
    RESET       = 3'd0,
    BOOT_SET    = 3'd1,
    SLEEP       = 3'd2,
    FIRST_FETCH = 3'd3,
    DECODE      = 3'd4,
    FLUSH_EX    = 3'd5,
    FLUSH_WB    = 3'd6
  } ctrl_state_e;

  // pc mux select toward the fetch stage
  typedef enum logic [2:0] {
    PC_BOOT      = 3'd0,
    PC_JUMP      = 3'd1,
    PC_BRANCH    = 3'd2,
    PC_EXCEPTION = 3'd3,
    PC_ERET      = 3'd4
  } pc_sel_e;

  // operand source for the id stage read ports
  typedef enum logic [1:0] {
    SEL_REGFILE = 2'd0,
    SEL_FW_EX   = 2'd1,
    SEL_FW_WB   = 2'd2
  } fw_sel_e;

  // kind of control transfer seen by the decoder
  typedef enum logic [1:0] {
    BRANCH_NONE = 2'd0,
    BRANCH_JAL  = 2'd1,
    BRANCH_JALR = 2'd2,
    BRANCH_COND = 2'd3
  } jump_kind_e;

  localparam ctrl_state_e RESET_STATE = RESET;

  //////////////////////////////
  // bundles
  //////////////////////////////

  // destination of a stage matches source a, b or c
  typedef struct packed {
    logic a;
    logic b;
    logic c;
  } operand_hit_t;

  // write enables and address matches of ex, wb and the alu result path
  typedef struct packed {
    logic         we_ex;
    logic         we_wb;
    logic         we_alu;
    operand_hit_t ex_hit;
    operand_hit_t wb_hit;
    operand_hit_t alu_hit;
  } fwd_src_t;

  typedef struct packed {
    logic       illegal;
    logic       eret;
    logic       pipe_flush;
    jump_kind_e jump;
  } decode_info_t;

  typedef struct packed {
    logic instr_valid;
    logic id_ready;
    logic ex_valid;
  } pipe_status_t;

  // one bit per redirect source
  typedef struct packed {
    logic boot;
    logic exc;
    logic jump;
    logic eret;
    logic branch;
  } redirect_req_t;

  typedef struct packed {
    logic    pc_set;
    pc_sel_e pc_mux;
  } pc_ctrl_t;

  typedef struct packed {
    logic halt_if;
    logic halt_id;
  } halt_t;

  typedef struct packed {
    fw_sel_e sel_a;
    fw_sel_e sel_b;
    fw_sel_e sel_c;
  } fw_sel_vec_t;

endpackage

// ==== design/ctrl_sequencer.sv ====
// controller sequencer: FSM for boot, decode, exception entry, pipeline flush and sleep
`timescale 1ns/10ps

module ctrl_sequencer
(
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    fetch_enable_i,
  input  logic                    exc_req_i,
  input  logic                    branch_taken_i,
  input  ctrl_pkg::decode_info_t  dec_i,
  input  ctrl_pkg::pipe_status_t  pipe_i,
  input  logic                    jr_stall_i,
  input  logic                    exc_grant_i,
  output ctrl_pkg::redirect_req_t redirect_o,
  output ctrl_pkg::halt_t         halt_o,
  output logic                    busy_o,
  output logic                    instr_req_o,
  output logic                    is_decoding_o,
  output logic                    exc_save_if_o,
  output logic                    exc_save_id_o,
  output logic                    exc_restore_id_o
);
  import ctrl_pkg::*;

  ctrl_state_e state_q;
  ctrl_state_e state_d;
  logic        jump_done_q;
  logic        jump_done_d;

  //////////////////////////////
  // next state and outputs
  //////////////////////////////

  always_comb
  begin
    // defaults: fetching, busy, no redirect
    state_d          = state_q;
    jump_done_d      = jump_done_q;
    redirect_o       = '0;
    halt_o           = '0;
    busy_o           = 1'b1;
    instr_req_o      = 1'b1;
    is_decoding_o    = 1'b0;
    exc_save_if_o    = 1'b0;
    exc_save_id_o    = 1'b0;
    exc_restore_id_o = 1'b0;

    case (state_q)
      // idle until the core is enabled
      RESET:
      begin
        busy_o      = 1'b0;
        instr_req_o = 1'b0;
        if (fetch_enable_i)
          state_d = BOOT_SET;
      end

      // load the boot address into the fetch stage, single cycle
      BOOT_SET:
      begin
        redirect_o.boot = 1'b1;
        state_d         = FIRST_FETCH;
      end

      // pipeline empty, wake on enable or an exception
      SLEEP:
      begin
        busy_o         = 1'b0;
        instr_req_o    = 1'b0;
        halt_o.halt_if = 1'b1;
        halt_o.halt_id = 1'b1;
        if (fetch_enable_i || exc_req_i)
          state_d = FIRST_FETCH;
      end

      // wait for the first instruction to reach id
      FIRST_FETCH:
      begin
        if (pipe_i.id_ready)
          state_d = DECODE;
        redirect_o.branch = branch_taken_i;
        redirect_o.exc    = exc_req_i;
        // the if pc is saved only when the exception actually wins
        exc_save_if_o     = exc_grant_i;
      end

      DECODE:
      begin
        // a taken branch in ex kills the instruction in id
        if (pipe_i.instr_valid && !branch_taken_i)
        begin
          is_decoding_o = 1'b1;

          // jal/jalr target is known here, fire once and wait out a jr hazard
          if (dec_i.jump == BRANCH_JAL || dec_i.jump == BRANCH_JALR)
          begin
            if (!jr_stall_i && !jump_done_q)
            begin
              redirect_o.jump = 1'b1;
              jump_done_d     = 1'b1;
            end
          end
          else if (exc_req_i)
          begin
            redirect_o.exc = 1'b1;
            // keep the faulting instruction out of ex
            halt_o.halt_id = exc_grant_i;
            exc_save_id_o  = exc_grant_i;
          end

          if (dec_i.eret)
          begin
            exc_restore_id_o = 1'b1;
            if (!jump_done_q)
            begin
              redirect_o.eret = 1'b1;
              jump_done_d     = 1'b1;
            end
          end

          // wfi-style flush, or eret that drops back to sleep
          if (dec_i.pipe_flush || (dec_i.eret && !fetch_enable_i))
          begin
            halt_o.halt_if = 1'b1;
            halt_o.halt_id = 1'b1;
            state_d        = FLUSH_EX;
          end
        end

        if (branch_taken_i)
          redirect_o.branch = 1'b1;
      end

      // let ex finish, nothing new enters
      FLUSH_EX:
      begin
        halt_o.halt_if = 1'b1;
        halt_o.halt_id = 1'b1;
        if (pipe_i.ex_valid)
          state_d = FLUSH_WB;
      end

      // wb drains in one cycle
      FLUSH_WB:
      begin
        halt_o.halt_id = 1'b1;
        if (fetch_enable_i)
        begin
          state_d = DECODE;
        end
        else
        begin
          halt_o.halt_if = 1'b1;
          state_d        = SLEEP;
        end
      end

      default:
      begin
        instr_req_o = 1'b0;
        state_d     = RESET;
      end
    endcase
  end

  //////////////////////////////
  // registers
  //////////////////////////////

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state_q     <= RESET_STATE;
      jump_done_q <= 1'b0;
    end
    else
    begin
      state_q     <= state_d;
      // cleared once id accepts the next instruction
      jump_done_q <= jump_done_d & ~pipe_i.id_ready;
    end
  end

endmodule

// ==== design/pc_redirect_arb.sv ====
// pc redirect arbiter: fixed-priority merge of redirect requests onto pc_set/pc_mux
`timescale 1ns/10ps

module pc_redirect_arb
(
  input  ctrl_pkg::redirect_req_t req_i,
  output ctrl_pkg::pc_ctrl_t      pc_o,
  output logic                    exc_grant_o
);
  import ctrl_pkg::*;

  //////////////////////////////
  // priority select
  //////////////////////////////

  // branch > eret > jump > exc > boot
  always_comb
  begin
    pc_o.pc_set = req_i.branch | req_i.eret | req_i.jump | req_i.exc | req_i.boot;
    exc_grant_o = 1'b0;

    if (req_i.branch)
    begin
      // branch in ex is older than anything in id
      pc_o.pc_mux = PC_BRANCH;
    end
    else if (req_i.eret)
    begin
      pc_o.pc_mux = PC_ERET;
    end
    else if (req_i.jump)
    begin
      pc_o.pc_mux = PC_JUMP;
    end
    else if (req_i.exc)
    begin
      pc_o.pc_mux = PC_EXCEPTION;
      // only grant the exception source when it owns the redirect
      exc_grant_o = 1'b1;
    end
    else
    begin
      // boot, or don't care while pc_set is low
      pc_o.pc_mux = PC_BOOT;
    end
  end

endmodule

// ==== design/hazard_unit.sv ====
// hazard unit: load-use, jump-register and misaligned stalls plus write-enable kill
`timescale 1ns/10ps

module hazard_unit
(
  input  logic                   is_decoding_i,
  input  logic                   data_req_ex_i,
  input  logic                   data_misaligned_i,
  input  ctrl_pkg::decode_info_t dec_i,
  input  ctrl_pkg::fwd_src_t     fwd_i,
  output logic                   load_stall_o,
  output logic                   jr_stall_o,
  output logic                   misaligned_stall_o,
  output logic                   deassert_we_o
);
  import ctrl_pkg::*;

  logic ex_hits_any;
  logic a_pending;

  //////////////////////////////
  // stall detection
  //////////////////////////////

  // some source reads the register the ex stage writes
  assign ex_hits_any = fwd_i.ex_hit.a | fwd_i.ex_hit.b | fwd_i.ex_hit.c;

  // operand a still being produced further down the pipe
  assign a_pending = (fwd_i.we_wb  & fwd_i.wb_hit.a) |
                     (fwd_i.we_ex  & fwd_i.ex_hit.a) |
                     (fwd_i.we_alu & fwd_i.alu_hit.a);

  // load data only shows up in wb, no forward from ex possible
  assign load_stall_o = data_req_ex_i & fwd_i.we_ex & ex_hits_any;

  // jalr target is computed in id, it needs rs1 settled
  assign jr_stall_o = (dec_i.jump == BRANCH_JALR) & a_pending;

  // second beat of a misaligned access owns the lsu
  assign misaligned_stall_o = data_misaligned_i;

  //////////////////////////////
  // write enable kill
  //////////////////////////////

  // the id instruction must not write back while stalled, illegal,
  // or outside decode
  assign deassert_we_o = load_stall_o       |
                         jr_stall_o         |
                         misaligned_stall_o |
                         dec_i.illegal      |
                         ~is_decoding_i;

endmodule

// ==== design/fwd_unit.sv ====
// forwarding unit: operand source selects for id read ports a, b and c
`timescale 1ns/10ps

module fwd_unit
(
  input  ctrl_pkg::fwd_src_t    fwd_i,
  input  logic                  data_misaligned_i,
  input  logic                  mult_multicycle_i,
  output ctrl_pkg::fw_sel_vec_t fw_sel_o
);
  import ctrl_pkg::*;

  // per-operand source, the alu path is newer than wb and wins
  function automatic fw_sel_e pick_src
  (
    input logic wb_hit,
    input logic alu_hit,
    input logic we_wb,
    input logic we_alu
  );
    fw_sel_e sel;
    sel = SEL_REGFILE;
    if (we_wb && wb_hit)
      sel = SEL_FW_WB;
    if (we_alu && alu_hit)
      sel = SEL_FW_EX;
    return sel;
  endfunction

  //////////////////////////////
  // select logic
  //////////////////////////////

  always_comb
  begin
    fw_sel_o.sel_a = pick_src(fwd_i.wb_hit.a, fwd_i.alu_hit.a, fwd_i.we_wb, fwd_i.we_alu);
    fw_sel_o.sel_b = pick_src(fwd_i.wb_hit.b, fwd_i.alu_hit.b, fwd_i.we_wb, fwd_i.we_alu);
    fw_sel_o.sel_c = pick_src(fwd_i.wb_hit.c, fwd_i.alu_hit.c, fwd_i.we_wb, fwd_i.we_alu);

    // misaligned second beat: address from ex result, no offset
    if (data_misaligned_i)
    begin
      fw_sel_o.sel_a = SEL_FW_EX;
      fw_sel_o.sel_b = SEL_REGFILE;
    end
    else if (mult_multicycle_i)
    begin
      // multicycle mul keeps its partial result on port c
      fw_sel_o.sel_c = SEL_FW_EX;
    end
  end

endmodule

// ==== design/core_controller.sv ====
// core controller top: sequencer, redirect arbiter, hazard and forwarding units
`timescale 1ns/10ps

module core_controller
(
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   fetch_enable_i,
  input  logic                   exc_req_i,
  input  logic                   branch_taken_i,
  input  logic                   data_req_ex_i,
  input  logic                   data_misaligned_i,
  input  logic                   mult_multicycle_i,
  input  ctrl_pkg::decode_info_t dec_i,
  input  ctrl_pkg::pipe_status_t pipe_i,
  input  ctrl_pkg::fwd_src_t     fwd_i,
  output logic                   busy_o,
  output logic                   is_decoding_o,
  output logic                   instr_req_o,
  output ctrl_pkg::pc_ctrl_t     pc_o,
  output logic                   exc_ack_o,
  output logic                   exc_save_if_o,
  output logic                   exc_save_id_o,
  output logic                   exc_restore_id_o,
  output ctrl_pkg::halt_t        halt_o,
  output logic                   deassert_we_o,
  output logic                   load_stall_o,
  output logic                   jr_stall_o,
  output logic                   misaligned_stall_o,
  output ctrl_pkg::fw_sel_vec_t  fw_sel_o
);
  import ctrl_pkg::*;

  // sequencer requests into the shared redirect path
  redirect_req_t redirect;

  ctrl_sequencer u_sequencer (
    .clk              (clk),
    .rst_n            (rst_n),
    .fetch_enable_i   (fetch_enable_i),
    .exc_req_i        (exc_req_i),
    .branch_taken_i   (branch_taken_i),
    .dec_i            (dec_i),
    .pipe_i           (pipe_i),
    .jr_stall_i       (jr_stall_o),
    .exc_grant_i      (exc_ack_o),
    .redirect_o       (redirect),
    .halt_o           (halt_o),
    .busy_o           (busy_o),
    .instr_req_o      (instr_req_o),
    .is_decoding_o    (is_decoding_o),
    .exc_save_if_o    (exc_save_if_o),
    .exc_save_id_o    (exc_save_id_o),
    .exc_restore_id_o (exc_restore_id_o)
  );

  // the exception grant doubles as the ack to the requester
  pc_redirect_arb u_redirect_arb (
    .req_i       (redirect),
    .pc_o        (pc_o),
    .exc_grant_o (exc_ack_o)
  );

  hazard_unit u_hazard (
    .is_decoding_i      (is_decoding_o),
    .data_req_ex_i      (data_req_ex_i),
    .data_misaligned_i  (data_misaligned_i),
    .dec_i              (dec_i),
    .fwd_i              (fwd_i),
    .load_stall_o       (load_stall_o),
    .jr_stall_o         (jr_stall_o),
    .misaligned_stall_o (misaligned_stall_o),
    .deassert_we_o      (deassert_we_o)
  );

  fwd_unit u_fwd (
    .fwd_i             (fwd_i),
    .data_misaligned_i (data_misaligned_i),
    .mult_multicycle_i (mult_multicycle_i),
    .fw_sel_o          (fw_sel_o)
  );

endmodule

// ==== sim/ctrl_checker.sv ====
// sequencer assertions: branch spacing, exception grant and the boot redirect
`timescale 1ns/10ps

module ctrl_checker
(
  input logic                    clk,
  input logic                    rst_n,
  input ctrl_pkg::ctrl_state_e   state_i,
  input ctrl_pkg::redirect_req_t redirect_i,
  input logic                    exc_req_i,
  input logic                    exc_grant_i
);
  import ctrl_pkg::*;

  int fail_count = 0;

  // ex never resolves two taken branches back to back
  branch_spacing: assert property (@(posedge clk) disable iff (!rst_n)
    redirect_i.branch |=> !redirect_i.branch)
  else
  begin
    fail_count++;
    $error("taken branch redirect seen in two consecutive cycles");
  end

  // grant pulse only while the requester holds exc_req
  ack_with_req: assert property (@(posedge clk) disable iff (!rst_n)
    exc_grant_i |-> exc_req_i)
  else
  begin
    fail_count++;
    $error("exception grant without an exception request");
  end

  // boot pc is loaded straight out of reset
  boot_after_reset: assert property (@(posedge clk) disable iff (!rst_n)
    redirect_i.boot |-> $past(state_i == RESET))
  else
  begin
    fail_count++;
    $error("boot redirect not preceded by the reset state");
  end

endmodule

bind ctrl_sequencer ctrl_checker u_checker
(
  .clk         (clk),
  .rst_n       (rst_n),
  .state_i     (state_q),
  .redirect_i  (redirect_o),
  .exc_req_i   (exc_req_i),
  .exc_grant_i (exc_grant_i)
);

// ==== sim/tb_types.svh ====
// expected-value bundle shared by the controller testbench and its output monitor
`ifndef TB_TYPES_SVH
`define TB_TYPES_SVH

// one cycle of expected controller outputs, with per-group check enables
typedef struct packed {
  logic                  chk_seq;
  logic                  chk_haz;
  logic                  chk_fwd;
  logic                  busy;
  logic                  instr_req;
  logic                  is_decoding;
  ctrl_pkg::pc_ctrl_t    pc;
  logic                  exc_ack;
  logic                  exc_save_if;
  logic                  exc_save_id;
  logic                  exc_restore_id;
  ctrl_pkg::halt_t       halt;
  logic                  load_stall;
  logic                  jr_stall;
  logic                  misaligned_stall;
  logic                  deassert_we;
  ctrl_pkg::fw_sel_vec_t fw_sel;
} exp_t;

`endif

// ==== sim/ctrl_monitor.sv ====
// output monitor: compares controller outputs with the expected values of each cycle
`timescale 1ns/10ps
`include "tb_types.svh"

module ctrl_monitor
(
  input  logic                  clk,
  input  logic                  rst_n,
  input  exp_t                  exp_i,
  input  logic                  busy_i,
  input  logic                  instr_req_i,
  input  logic                  is_decoding_i,
  input  ctrl_pkg::pc_ctrl_t    pc_i,
  input  logic                  exc_ack_i,
  input  logic                  exc_save_if_i,
  input  logic                  exc_save_id_i,
  input  logic                  exc_restore_id_i,
  input  ctrl_pkg::halt_t       halt_i,
  input  logic                  load_stall_i,
  input  logic                  jr_stall_i,
  input  logic                  misaligned_stall_i,
  input  logic                  deassert_we_i,
  input  ctrl_pkg::fw_sel_vec_t fw_sel_i,
  output int                    err_count_o
);

  int errs = 0;

  assign err_count_o = errs;

  // one named field, printed in hex on a miss
  task automatic check_field(input string name, input logic [7:0] got, input logic [7:0] want);
    if (got !== want)
    begin
      errs++;
      $display("Mismatch at %0t ns: %s is %0h, expected %0h", $time, name, got, want);
    end
  endtask

  //////////////////////////////
  // compare on the rising edge
  //////////////////////////////

  // inputs change on the falling edge, so outputs are settled here
  always @(posedge clk)
  begin
    if (rst_n && exp_i.chk_seq)
    begin
      check_field("busy_o", busy_i, exp_i.busy);
      check_field("instr_req_o", instr_req_i, exp_i.instr_req);
      check_field("is_decoding_o", is_decoding_i, exp_i.is_decoding);
      check_field("pc_set", pc_i.pc_set, exp_i.pc.pc_set);
      // mux value only matters with pc_set
      if (exp_i.pc.pc_set)
        check_field("pc_mux", pc_i.pc_mux, exp_i.pc.pc_mux);
      check_field("exc_ack_o", exc_ack_i, exp_i.exc_ack);
      check_field("exc_save_if_o", exc_save_if_i, exp_i.exc_save_if);
      check_field("exc_save_id_o", exc_save_id_i, exp_i.exc_save_id);
      check_field("exc_restore_id_o", exc_restore_id_i, exp_i.exc_restore_id);
      check_field("halt_o", halt_i, exp_i.halt);
    end
    if (rst_n && exp_i.chk_haz)
    begin
      check_field("load_stall_o", load_stall_i, exp_i.load_stall);
      check_field("jr_stall_o", jr_stall_i, exp_i.jr_stall);
      check_field("misaligned_stall_o", misaligned_stall_i, exp_i.misaligned_stall);
      check_field("deassert_we_o", deassert_we_i, exp_i.deassert_we);
    end
    if (rst_n && exp_i.chk_fwd)
    begin
      check_field("sel_a", fw_sel_i.sel_a, exp_i.fw_sel.sel_a);
      check_field("sel_b", fw_sel_i.sel_b, exp_i.fw_sel.sel_b);
      check_field("sel_c", fw_sel_i.sel_c, exp_i.fw_sel.sel_c);
    end
  end

endmodule

// ==== sim/tb_core_controller.sv ====
// testbench for the core controller: boot, forwarding, stalls, redirects, exception and sleep
`timescale 1ns/10ps
`include "tb_types.svh"

module tb_core_controller;
  import ctrl_pkg::*;

  // all DUT inputs of one cycle
  typedef struct packed {
    logic         fetch_enable;
    logic         exc_req;
    logic         branch_taken;
    logic         data_req_ex;
    logic         data_misaligned;
    logic         mult_multicycle;
    decode_info_t dec;
    pipe_status_t pipe;
    fwd_src_t     fwd;
  } stim_t;

  typedef enum int {ROW_APPLY, ROW_WAIT_DECODE, ROW_WAIT_SLEEP} row_op_e;

  logic        clk;
  logic        rst_n;
  stim_t       stim;
  exp_t        exp_cur;
  int          mismatch_count;
  int          timeout_count;
  int          assert_count;
  logic        busy;
  logic        is_decoding;
  logic        instr_req;
  logic        exc_ack;
  logic        exc_save_if;
  logic        exc_save_id;
  logic        exc_restore_id;
  logic        deassert_we;
  logic        load_stall;
  logic        jr_stall;
  logic        misaligned_stall;
  pc_ctrl_t    pc;
  halt_t       halt;
  fw_sel_vec_t fw_sel;

  // stimulus table, one entry per cycle or wait step
  stim_t   stim_tab[$];
  exp_t    exp_tab[$];
  row_op_e op_tab[$];

  core_controller DUT (
    .clk                (clk),
    .rst_n              (rst_n),
    .fetch_enable_i     (stim.fetch_enable),
    .exc_req_i          (stim.exc_req),
    .branch_taken_i     (stim.branch_taken),
    .data_req_ex_i      (stim.data_req_ex),
    .data_misaligned_i  (stim.data_misaligned),
    .mult_multicycle_i  (stim.mult_multicycle),
    .dec_i              (stim.dec),
    .pipe_i             (stim.pipe),
    .fwd_i              (stim.fwd),
    .busy_o             (busy),
    .is_decoding_o      (is_decoding),
    .instr_req_o        (instr_req),
    .pc_o               (pc),
    .exc_ack_o          (exc_ack),
    .exc_save_if_o      (exc_save_if),
    .exc_save_id_o      (exc_save_id),
    .exc_restore_id_o   (exc_restore_id),
    .halt_o             (halt),
    .deassert_we_o      (deassert_we),
    .load_stall_o       (load_stall),
    .jr_stall_o         (jr_stall),
    .misaligned_stall_o (misaligned_stall),
    .fw_sel_o           (fw_sel)
  );

  ctrl_monitor u_monitor (
    .clk                (clk),
    .rst_n              (rst_n),
    .exp_i              (exp_cur),
    .busy_i             (busy),
    .instr_req_i        (instr_req),
    .is_decoding_i      (is_decoding),
    .pc_i               (pc),
    .exc_ack_i          (exc_ack),
    .exc_save_if_i      (exc_save_if),
    .exc_save_id_i      (exc_save_id),
    .exc_restore_id_i   (exc_restore_id),
    .halt_i             (halt),
    .load_stall_i       (load_stall),
    .jr_stall_i         (jr_stall),
    .misaligned_stall_i (misaligned_stall),
    .deassert_we_i      (deassert_we),
    .fw_sel_i           (fw_sel),
    .err_count_o        (mismatch_count)
  );

  initial
  begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  //////////////////////////////
  // expected value rules
  //////////////////////////////

  // newest writer wins: alu result over wb, wb over the register file
  function automatic fw_sel_e expect_src(input logic wb_fwd, input logic alu_fwd);
    if (alu_fwd)
      return SEL_FW_EX;
    if (wb_fwd)
      return SEL_FW_WB;
    return SEL_REGFILE;
  endfunction

  function automatic fw_sel_vec_t expect_fwd(input fwd_src_t f, input logic mis, input logic mul);
    fw_sel_vec_t v;
    v.sel_a = expect_src(f.we_wb & f.wb_hit.a, f.we_alu & f.alu_hit.a);
    v.sel_b = expect_src(f.we_wb & f.wb_hit.b, f.we_alu & f.alu_hit.b);
    v.sel_c = expect_src(f.we_wb & f.wb_hit.c, f.we_alu & f.alu_hit.c);
    // misaligned beat overrides, multicycle mul only otherwise
    if (mis)
    begin
      v.sel_a = SEL_FW_EX;
      v.sel_b = SEL_REGFILE;
    end
    else if (mul)
    begin
      v.sel_c = SEL_FW_EX;
    end
    return v;
  endfunction

  // quiet cycle: no redirect, no stall, write enable follows decoding
  function automatic exp_t base_exp(input logic bsy, input logic dec_on, input halt_t hlt);
    exp_t e;
    e             = '0;
    e.chk_seq     = 1'b1;
    e.chk_haz     = 1'b1;
    e.chk_fwd     = 1'b1;
    e.busy        = bsy;
    e.instr_req   = bsy;
    e.is_decoding = dec_on;
    e.halt        = hlt;
    e.deassert_we = ~dec_on;
    return e;
  endfunction

  function automatic stim_t decode_stim(input logic fe, input logic id_ready);
    stim_t s;
    s                  = '0;
    s.fetch_enable     = fe;
    s.pipe.instr_valid = 1'b1;
    s.pipe.id_ready    = id_ready;
    return s;
  endfunction

  //////////////////////////////
  // table building
  //////////////////////////////

  task automatic add_row(input stim_t s, input exp_t e);
    e.fw_sel = expect_fwd(s.fwd, s.data_misaligned, s.mult_multicycle);
    stim_tab.push_back(s);
    exp_tab.push_back(e);
    op_tab.push_back(ROW_APPLY);
  endtask

  task automatic add_wait(input row_op_e op);
    stim_tab.push_back('0);
    exp_tab.push_back('0);
    op_tab.push_back(op);
  endtask

  task automatic build_table();
    stim_t       s;
    exp_t        e;
    logic [11:0] bits;
    int          i;

    // reset, enable, one boot cycle
    s = '0;
    add_row(s, base_exp(1'b0, 1'b0, 2'b00));
    s.fetch_enable = 1'b1;
    add_row(s, base_exp(1'b0, 1'b0, 2'b00));
    e    = base_exp(1'b1, 1'b0, 2'b00);
    e.pc = '{pc_set: 1'b1, pc_mux: PC_BOOT};
    add_row(s, e);
    add_wait(ROW_WAIT_DECODE);

    // random forwarding patterns while decoding
    for (i = 0; i < 12; i++)
    begin
      s                 = decode_stim(1'b1, 1'b1);
      bits              = 12'($urandom);
      s.fwd             = bits;
      s.data_misaligned = ($urandom % 4) == 0;
      s.mult_multicycle = ($urandom % 2) == 1;
      e                    = base_exp(1'b1, 1'b1, 2'b00);
      e.misaligned_stall   = s.data_misaligned;
      e.deassert_we        = s.data_misaligned;
      add_row(s, e);
    end

    // load in ex feeds operand b
    s               = decode_stim(1'b1, 1'b1);
    s.data_req_ex   = 1'b1;
    s.fwd.we_ex     = 1'b1;
    s.fwd.ex_hit.b  = 1'b1;
    e               = base_exp(1'b1, 1'b1, 2'b00);
    e.load_stall    = 1'b1;
    e.deassert_we   = 1'b1;
    add_row(s, e);

    // jalr waits on rs1 from wb, then redirects exactly once
    s              = decode_stim(1'b1, 1'b0);
    s.dec.jump     = BRANCH_JALR;
    s.fwd.we_wb    = 1'b1;
    s.fwd.wb_hit.a = 1'b1;
    e              = base_exp(1'b1, 1'b1, 2'b00);
    e.jr_stall     = 1'b1;
    e.deassert_we  = 1'b1;
    add_row(s, e);
    s.fwd = '0;
    e     = base_exp(1'b1, 1'b1, 2'b00);
    e.pc  = '{pc_set: 1'b1, pc_mux: PC_JUMP};
    add_row(s, e);
    add_row(s, base_exp(1'b1, 1'b1, 2'b00));
    s.pipe.id_ready = 1'b1;
    add_row(s, base_exp(1'b1, 1'b1, 2'b00));
    add_row(decode_stim(1'b1, 1'b1), base_exp(1'b1, 1'b1, 2'b00));

    // branch beats eret, jal and exception in the same cycle
    s              = decode_stim(1'b1, 1'b1);
    s.branch_taken = 1'b1;
    s.exc_req      = 1'b1;
    s.dec.eret     = 1'b1;
    s.dec.jump     = BRANCH_JAL;
    e              = base_exp(1'b1, 1'b0, 2'b00);
    e.pc           = '{pc_set: 1'b1, pc_mux: PC_BRANCH};
    add_row(s, e);
    add_row(decode_stim(1'b1, 1'b1), base_exp(1'b1, 1'b1, 2'b00));

    // exception taken in decode, requester drops after the ack
    s             = decode_stim(1'b1, 1'b1);
    s.exc_req     = 1'b1;
    e             = base_exp(1'b1, 1'b1, 2'b01);
    e.pc          = '{pc_set: 1'b1, pc_mux: PC_EXCEPTION};
    e.exc_ack     = 1'b1;
    e.exc_save_id = 1'b1;
    add_row(s, e);
    add_row(decode_stim(1'b1, 1'b1), base_exp(1'b1, 1'b1, 2'b00));

    // eret with fetch enabled returns to the saved pc and keeps decoding
    s                = decode_stim(1'b1, 1'b1);
    s.dec.eret       = 1'b1;
    e                = base_exp(1'b1, 1'b1, 2'b00);
    e.pc             = '{pc_set: 1'b1, pc_mux: PC_ERET};
    e.exc_restore_id = 1'b1;
    add_row(s, e);

    // flush with fetch disabled drains into sleep
    s                = decode_stim(1'b0, 1'b1);
    s.dec.pipe_flush = 1'b1;
    add_row(s, base_exp(1'b1, 1'b1, 2'b11));
    add_wait(ROW_WAIT_SLEEP);

    // asleep, then woken by an exception
    s = '0;
    add_row(s, base_exp(1'b0, 1'b0, 2'b11));
    s.exc_req = 1'b1;
    add_row(s, base_exp(1'b0, 1'b0, 2'b11));
    e             = base_exp(1'b1, 1'b0, 2'b00);
    e.pc          = '{pc_set: 1'b1, pc_mux: PC_EXCEPTION};
    e.exc_ack     = 1'b1;
    e.exc_save_if = 1'b1;
    add_row(s, e);
    s = '0;
    add_row(s, base_exp(1'b1, 1'b0, 2'b00));
  endtask

  //////////////////////////////
  // bounded waits
  //////////////////////////////

  // first fetch has a variable latency, id_ready marks its end
  task automatic wait_decode();
    int lat;
    int n;
    lat = $urandom % 4;
    n   = 0;
    while (!is_decoding && n < 25)
    begin
      stim    = decode_stim(1'b1, n >= lat);
      exp_cur = base_exp(1'b1, 1'b0, 2'b00);
      @(negedge clk);
      n++;
    end
    if (!is_decoding)
    begin
      timeout_count++;
      $display("Error at %0t ns: controller never reached decode after id_ready", $time);
    end
  endtask

  // ex finishes after a few cycles, then wb drains into sleep
  task automatic wait_sleep();
    stim_t s;
    int    lat;
    int    n;
    lat = 1 + $urandom % 4;
    n   = 0;
    while (busy && n < 25)
    begin
      s               = '0;
      s.pipe.ex_valid = n >= lat;
      stim            = s;
      exp_cur         = base_exp(1'b1, 1'b0, 2'b11);
      @(negedge clk);
      n++;
    end
    if (busy)
    begin
      timeout_count++;
      $display("Error at %0t ns: controller never went to sleep after ex_valid", $time);
    end
  endtask

  //////////////////////////////
  // main sequence
  //////////////////////////////

  initial
  begin
    void'($urandom(77873));
    rst_n         = 1'b0;
    stim          = '0;
    exp_cur       = '0;
    timeout_count = 0;
    build_table();
    repeat (4) @(negedge clk);
    rst_n = 1'b1;

    // inputs change on the falling edge, monitor checks on the rising one
    for (int r = 0; r < op_tab.size(); r++)
    begin
      case (op_tab[r])
        ROW_WAIT_DECODE:
          wait_decode();
        ROW_WAIT_SLEEP:
          wait_sleep();
        default:
        begin
          stim    = stim_tab[r];
          exp_cur = exp_tab[r];
          @(negedge clk);
        end
      endcase
    end

    exp_cur = '0;
    @(negedge clk);
    assert_count = DUT.u_sequencer.u_checker.fail_count;
    $display("Summary: %0d mismatches, %0d timeouts, %0d assertion failures",
             mismatch_count, timeout_count, assert_count);
    if (mismatch_count == 0 && timeout_count == 0 && assert_count == 0)
      $display("Done: no errors");
    else
      $display("Done: errors found");
    $finish;
  end

endmodule

// ==== flist.f ====
+incdir+sim
design/ctrl_pkg.sv
design/ctrl_sequencer.sv
design/pc_redirect_arb.sv
design/hazard_unit.sv
design/fwd_unit.sv
design/core_controller.sv
sim/ctrl_checker.sv
sim/ctrl_monitor.sv
sim/tb_core_controller.sv
